// ==== common/whirlpool_defines.svh ====
`ifndef WHIRLPOOL_DEFINES_SVH
`define WHIRLPOOL_DEFINES_SVH

// Number of W-cipher rounds per compression.
`define WP_ROUNDS 10

// Width of a message block, the chaining value and the cipher state.
`define WP_BLOCK_BITS 512

// Round counter width, enough for 1 to WP_ROUNDS.
`define WP_ROUND_BITS 4

`endif

// ==== common/whirlpool_ctrl_pkg.sv ====
`default_nettype none

package whirlpool_ctrl_pkg;

    // Command opcodes on the top-level command port.
    typedef enum logic [1:0] {
        CMD_INIT   = 2'd0,
        CMD_LOAD   = 2'd1,
        CMD_ABSORB = 2'd2
    } cmd_t;

    // Sequencing FSM states.
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_RUN    = 2'd1,
        ST_FINISH = 2'd2
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== common/whirlpool_data_pkg.sv ====
`default_nettype none

`include "whirlpool_defines.svh"

package whirlpool_data_pkg;

    // Indexed [row][col]; [0][0] is the first byte of the block.
    typedef logic [0:7][0:7][7:0] byte_matrix_t;

    // Current round, 1 to WP_ROUNDS.
    typedef logic [`WP_ROUND_BITS-1:0] round_idx_t;

endpackage

`default_nettype wire

// ==== whirlpool_cipher/whirlpool_sbox.sv ====
`timescale 1ns/1ps
`default_nettype none

module whirlpool_sbox (
    input  wire  [7:0] in_byte,
    output logic [7:0] out_byte
);

    localparam logic [3:0] e_tab [0:15] = '{
        4'h1, 4'hb, 4'h9, 4'hc, 4'hd, 4'h6, 4'hf, 4'h3,
        4'he, 4'h8, 4'h7, 4'h4, 4'ha, 4'h2, 4'h5, 4'h0
    };

    localparam logic [3:0] e_inv_tab [0:15] = '{
        4'hf, 4'h0, 4'hd, 4'h7, 4'hb, 4'he, 4'h5, 4'ha,
        4'h9, 4'h2, 4'hc, 4'h1, 4'h3, 4'h4, 4'h8, 4'h6
    };

    localparam logic [3:0] r_tab [0:15] = '{
        4'h7, 4'hc, 4'hb, 4'hd, 4'he, 4'h4, 4'h9, 4'hf,
        4'h6, 4'h3, 4'h8, 4'ha, 4'h2, 4'h5, 4'h1, 4'h0
    };

    logic [3:0] hi_e;
    logic [3:0] lo_e;
    logic [3:0] r_out;

    // First layer, high nibble through E, low through E inverse.
    assign hi_e = e_tab[in_byte[7:4]];
    assign lo_e = e_inv_tab[in_byte[3:0]];

    // Middle R box on the cross XOR.
    assign r_out = r_tab[hi_e ^ lo_e];

    // Second layer, fed back into both halves.
    assign out_byte[7:4] = e_tab[hi_e ^ r_out];
    assign out_byte[3:0] = e_inv_tab[lo_e ^ r_out];

endmodule

`default_nettype wire

// ==== whirlpool_cipher/whirlpool_round.sv ====
`timescale 1ns/1ps
`default_nettype none

module whirlpool_round (
    input  whirlpool_data_pkg::byte_matrix_t  state_in,
    input  whirlpool_data_pkg::byte_matrix_t  round_key,
    output whirlpool_data_pkg::byte_matrix_t  state_out
);

    // First row of the theta circulant.
    localparam logic [3:0] theta_coef [0:7] = '{
        4'h1, 4'h1, 4'h4, 4'h1, 4'h8, 4'h5, 4'h2, 4'h9
    };

    wire whirlpool_data_pkg::byte_matrix_t sub;
    wire whirlpool_data_pkg::byte_matrix_t perm;
    whirlpool_data_pkg::byte_matrix_t      mix;

    // Doubling in GF(2^8) modulo x^8+x^4+x^3+x^2+1.
    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1d : 8'h00);
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [3:0] c);
        logic [7:0] x2;
        logic [7:0] x4;
        logic [7:0] x8;
        x2 = xtime(a);
        x4 = xtime(x2);
        x8 = xtime(x4);
        return (c[0] ? a : 8'h00) ^ (c[1] ? x2 : 8'h00) ^
               (c[2] ? x4 : 8'h00) ^ (c[3] ? x8 : 8'h00);
    endfunction

    // Gamma on every byte, then pi rotates column j down by j rows.
    genvar i, j;
    for (i = 0; i < 8; i++) begin : g_row
        for (j = 0; j < 8; j++) begin : g_col
            whirlpool_sbox u_sbox (
                .in_byte  (state_in[i][j]),
                .out_byte (sub[i][j])
            );
            assign perm[(i + j) % 8][j] = sub[i][j];
        end
    end

    // Theta, each row times the circulant matrix.
    always_comb begin : theta
        logic [7:0] acc;
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) begin
                acc = 8'h00;
                for (int k = 0; k < 8; k++) begin
                    acc = acc ^ gf_mul(perm[r][k], theta_coef[(c - k + 8) % 8]);
                end
                mix[r][c] = acc;
            end
        end
    end

    // Sigma.
    assign state_out = mix ^ round_key;

endmodule

`default_nettype wire

// ==== whirlpool_cipher/whirlpool_cipher.sv ====
`timescale 1ns/1ps
`default_nettype none

module whirlpool_cipher (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               absorb_start,
    input  wire                               cipher_step,
    input  whirlpool_data_pkg::round_idx_t    round,
    input  whirlpool_data_pkg::byte_matrix_t  key_init,
    input  whirlpool_data_pkg::byte_matrix_t  state_init,
    output whirlpool_data_pkg::byte_matrix_t  cipher_result
);

    whirlpool_data_pkg::byte_matrix_t key_q;
    whirlpool_data_pkg::byte_matrix_t state_q;
    whirlpool_data_pkg::byte_matrix_t key_next;
    whirlpool_data_pkg::byte_matrix_t state_next;
    wire whirlpool_data_pkg::byte_matrix_t rc;
    logic [7:0]                       rc_base;

    // Round constant row 0 is S[8*(r-1) + j].
    assign rc_base = {1'b0, round - 4'd1, 3'b000};

    genvar i, j;
    for (j = 0; j < 8; j++) begin : g_rc_col
        whirlpool_sbox u_rc_sbox (
            .in_byte  (rc_base + 8'(j)),
            .out_byte (rc[0][j])
        );
        for (i = 1; i < 8; i++) begin : g_rc_zero
            assign rc[i][j] = 8'h00;
        end
    end

    // Key schedule round, then the state round under the new key.
    whirlpool_round u_key_round (
        .state_in  (key_q),
        .round_key (rc),
        .state_out (key_next)
    );

    whirlpool_round u_state_round (
        .state_in  (state_q),
        .round_key (key_next),
        .state_out (state_next)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            key_q   <= '0;
            state_q <= '0;
        end else if (absorb_start) begin
            key_q   <= key_init;
            state_q <= state_init;
        end else if (cipher_step) begin
            key_q   <= key_next;
            state_q <= state_next;
        end
    end

    assign cipher_result = state_q;

endmodule

`default_nettype wire

// ==== src/whirlpool_chain_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module whirlpool_chain_regs (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               chain_clear,
    input  wire                               chain_load,
    input  wire                               absorb_start,
    input  wire                               absorb_finish,
    input  whirlpool_data_pkg::byte_matrix_t  block,
    input  whirlpool_data_pkg::byte_matrix_t  cipher_result,
    output whirlpool_data_pkg::byte_matrix_t  chain,
    output whirlpool_data_pkg::byte_matrix_t  first_state
);

    whirlpool_data_pkg::byte_matrix_t msg;

    // Cipher input for the first round.
    assign first_state = block ^ chain;

    always_ff @(posedge clk) begin
        if (reset) begin
            chain <= '0;
        end else if (chain_clear) begin
            chain <= '0;
        end else if (chain_load) begin
            chain <= block;
        end else if (absorb_finish) begin
            // Miyaguchi-Preneel feed-forward.
            chain <= cipher_result ^ chain ^ msg;
        end
    end

    always_ff @(posedge clk) begin
        if (absorb_start) begin
            msg <= block;
        end
    end

endmodule

`default_nettype wire

// ==== src/whirlpool_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "whirlpool_defines.svh"

module whirlpool_ctrl (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             cmd_valid,
    input  whirlpool_ctrl_pkg::cmd_t        cmd,
    output logic                            busy,
    output logic                            done,
    output logic                            chain_clear,
    output logic                            chain_load,
    output logic                            absorb_start,
    output logic                            absorb_finish,
    output logic                            cipher_step,
    output whirlpool_data_pkg::round_idx_t  round
);

    whirlpool_ctrl_pkg::ctrl_state_t state;
    logic                            accept;

    // Commands are only taken in idle; anything else is dropped.
    assign accept        = cmd_valid && (state == whirlpool_ctrl_pkg::ST_IDLE);
    assign chain_clear   = accept && (cmd == whirlpool_ctrl_pkg::CMD_INIT);
    assign chain_load    = accept && (cmd == whirlpool_ctrl_pkg::CMD_LOAD);
    assign absorb_start  = accept && (cmd == whirlpool_ctrl_pkg::CMD_ABSORB);
    assign absorb_finish = (state == whirlpool_ctrl_pkg::ST_FINISH);
    assign cipher_step   = (state == whirlpool_ctrl_pkg::ST_RUN);
    assign busy          = (state != whirlpool_ctrl_pkg::ST_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= whirlpool_ctrl_pkg::ST_IDLE;
            round <= 4'd1;
            done  <= 1'b0;
        end else begin
            done <= (state == whirlpool_ctrl_pkg::ST_FINISH);
            case (state)
                whirlpool_ctrl_pkg::ST_IDLE: begin
                    if (absorb_start) begin
                        state <= whirlpool_ctrl_pkg::ST_RUN;
                        round <= 4'd1;
                    end
                end
                whirlpool_ctrl_pkg::ST_RUN: begin
                    // One round per cycle, last one at WP_ROUNDS.
                    if (round == `WP_ROUNDS) begin
                        state <= whirlpool_ctrl_pkg::ST_FINISH;
                    end else begin
                        round <= round + 4'd1;
                    end
                end
                whirlpool_ctrl_pkg::ST_FINISH: begin
                    state <= whirlpool_ctrl_pkg::ST_IDLE;
                end
                default: begin
                    state <= whirlpool_ctrl_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/whirlpool_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "whirlpool_defines.svh"

module whirlpool_top (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               cmd_valid,
    input  whirlpool_ctrl_pkg::cmd_t          cmd,
    input  wire        [`WP_BLOCK_BITS-1:0]   block,
    output logic                              busy,
    output logic                              done,
    output logic       [`WP_BLOCK_BITS-1:0]   digest
);

    logic                              chain_clear;
    logic                              chain_load;
    logic                              absorb_start;
    logic                              absorb_finish;
    logic                              cipher_step;
    whirlpool_data_pkg::round_idx_t    round;
    whirlpool_data_pkg::byte_matrix_t  chain;
    whirlpool_data_pkg::byte_matrix_t  first_state;
    whirlpool_data_pkg::byte_matrix_t  cipher_result;

    whirlpool_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .busy          (busy),
        .done          (done),
        .chain_clear   (chain_clear),
        .chain_load    (chain_load),
        .absorb_start  (absorb_start),
        .absorb_finish (absorb_finish),
        .cipher_step   (cipher_step),
        .round         (round)
    );

    whirlpool_chain_regs u_chain_regs (
        .clk           (clk),
        .reset         (reset),
        .chain_clear   (chain_clear),
        .chain_load    (chain_load),
        .absorb_start  (absorb_start),
        .absorb_finish (absorb_finish),
        .block         (block),
        .cipher_result (cipher_result),
        .chain         (chain),
        .first_state   (first_state)
    );

    whirlpool_cipher u_cipher (
        .clk           (clk),
        .reset         (reset),
        .absorb_start  (absorb_start),
        .cipher_step   (cipher_step),
        .round         (round),
        .key_init      (chain),
        .state_init    (first_state),
        .cipher_result (cipher_result)
    );

    // The chaining value is the digest.
    assign digest = chain;

endmodule

`default_nettype wire

// ==== test/whirlpool_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module whirlpool_assert (
    input wire clk,
    input wire reset,
    input wire busy,
    input wire done,
    input wire absorb_start
);

    // Done is a one-cycle pulse.
    done_single_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done stayed high for two cycles");

    // Eleven edges from the absorb to the done pulse.
    done_after_absorb: assert property (@(posedge clk) disable iff (reset)
        absorb_start |=> !done [*11] ##1 done)
        else $error("done did not follow the absorb after 11 cycles");

    idle_after_reset: assert property (@(posedge clk)
        reset |=> !busy && !done)
        else $error("busy or done high after reset");

endmodule

bind whirlpool_ctrl whirlpool_assert u_assert (
    .clk          (clk),
    .reset        (reset),
    .busy         (busy),
    .done         (done),
    .absorb_start (absorb_start)
);

`default_nettype wire

// ==== test/whirlpool_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "whirlpool_defines.svh"

module whirlpool_tb;

    // Room for about 20 absorbs with their idle cycles.
    localparam int timeout_cycles = 20 * (`WP_ROUNDS + 10);
    // Published Whirlpool hash of the empty string.
    localparam logic [`WP_BLOCK_BITS-1:0] empty_digest = {
        256'h19fa61d75522a4669b44e39c1d2e1726c530232130d407f89afee0964997f7a7,
        256'h3e83be698b288febcf88e3e03c4f0757ea8964e59b63d93708b138cc42a66eb3};
    // Mini-boxes and theta circulant row of the hash specification.
    localparam logic [3:0] e_box [16] = '{1, 11, 9, 12, 13, 6, 15, 3,
        14, 8, 7, 4, 10, 2, 5, 0};
    localparam logic [3:0] e_inv_box [16] = '{15, 0, 13, 7, 11, 14, 5, 10,
        9, 2, 12, 1, 3, 4, 8, 6};
    localparam logic [3:0] r_box [16] = '{7, 12, 11, 13, 14, 4, 9, 15,
        6, 3, 8, 10, 2, 5, 1, 0};
    localparam int circ [8] = '{1, 1, 4, 1, 8, 5, 2, 9};

    logic                             clk;
    logic                             reset;
    logic                             cmd_valid;
    whirlpool_ctrl_pkg::cmd_t         cmd;
    logic [`WP_BLOCK_BITS-1:0]        block;
    wire                              busy;
    wire                              done;
    wire  [`WP_BLOCK_BITS-1:0]        digest;
    integer                           seed;
    int                               cycle_count = 0;
    whirlpool_data_pkg::byte_matrix_t model_chain;

    whirlpool_top DUT (.clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd(cmd),
        .block(block), .busy(busy), .done(done), .digest(digest));

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            stop_with_failure("timeout: the tests did not finish within the cycle limit");
        end
    end

    function automatic logic [7:0] sbox(input logic [7:0] x);
        logic [3:0] u;
        logic [3:0] l;
        logic [3:0] r;
        u = e_box[x[7:4]];
        l = e_inv_box[x[3:0]];
        r = r_box[u ^ l];
        return {e_box[u ^ r], e_inv_box[l ^ r]};
    endfunction

    // Gamma and pi, then theta with the key as the starting value.
    function automatic whirlpool_data_pkg::byte_matrix_t round_fn(
            input whirlpool_data_pkg::byte_matrix_t m, input whirlpool_data_pkg::byte_matrix_t k);
        whirlpool_data_pkg::byte_matrix_t p;
        logic [7:0] s;
        for (int i = 0; i < 64; i++) begin
            p[(i / 8 + i % 8) % 8][i % 8] = sbox(m[i / 8][i % 8]);
        end
        for (int i = 0; i < 64; i++) begin
            for (int n = 0; n < 8; n++) begin
                s = p[i / 8][n];
                for (int b = 0; b < 4; b++) begin
                    k[i / 8][i % 8] ^= s & {8{circ[(i % 8 - n + 8) % 8][b]}};
                    s = {s[6:0], 1'b0} ^ (s[7] ? 8'h1d : 8'h00);
                end
            end
        end
        return k;
    endfunction

    // Miyaguchi-Preneel compression over the W cipher.
    function automatic whirlpool_data_pkg::byte_matrix_t compress(
            input whirlpool_data_pkg::byte_matrix_t h, input whirlpool_data_pkg::byte_matrix_t m);
        whirlpool_data_pkg::byte_matrix_t k;
        whirlpool_data_pkg::byte_matrix_t s;
        whirlpool_data_pkg::byte_matrix_t rc;
        k = h;
        s = m ^ h;
        for (int r = 0; r < `WP_ROUNDS; r++) begin
            rc = '0;
            for (int j = 0; j < 8; j++) begin
                rc[0][j] = sbox(8'(8 * r + j));
            end
            k = round_fn(k, rc);
            s = round_fn(s, k);
        end
        return s ^ h ^ m;
    endfunction

    function automatic logic [`WP_BLOCK_BITS-1:0] rand_block();
        logic [`WP_BLOCK_BITS-1:0] b;
        for (int w = 0; w < 16; w++) begin
            b[32 * w +: 32] = $random(seed);
        end
        return b;
    endfunction

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_matrix(input string what, input whirlpool_data_pkg::byte_matrix_t expected,
            input whirlpool_data_pkg::byte_matrix_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("error at time %0t: %s, expected %h, got %h",
                $time, what, expected, actual));
        end
    endtask

    task automatic check_flag(input string what, input bit expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("error at time %0t: %s, expected %b, got %b",
                $time, what, expected, actual));
        end
    endtask

    task automatic issue_cmd(input whirlpool_ctrl_pkg::cmd_t op,
            input logic [`WP_BLOCK_BITS-1:0] data);
        cmd_valid = 1'b1;
        cmd = op;
        block = data;
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
    endtask

    // Absorb one block while issuing commands in its first busy cycles.
    task automatic absorb_checked(input logic [`WP_BLOCK_BITS-1:0] data, input int dropped);
        whirlpool_data_pkg::byte_matrix_t prev;
        int n;
        prev = model_chain;
        model_chain = compress(prev, data);
        n = 0;
        issue_cmd(whirlpool_ctrl_pkg::CMD_ABSORB, data);
        while (!done && n < 2 * `WP_ROUNDS) begin
            check_flag("busy during the rounds", 1'b1, busy);
            check_matrix("digest during the rounds", prev, digest);
            if (n < dropped) begin
                issue_cmd(whirlpool_ctrl_pkg::cmd_t'(n % 3), rand_block());
            end else begin
                @(posedge clk);
                #2;
            end
            n++;
        end
        check_flag("done 11 cycles after the absorb", 1'b1, n == `WP_ROUNDS + 1);
        check_flag("busy in the done cycle", 1'b0, busy);
        check_matrix("digest after the absorb", model_chain, digest);
    endtask

    task automatic idle_no_done(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #2;
            check_flag("done while idle", 1'b0, done);
        end
    endtask

    task automatic after_reset();
        check_matrix("digest after reset", '0, digest);
        check_flag("busy after reset", 1'b0, busy);
        check_flag("done after reset", 1'b0, done);
    endtask

    task automatic empty_string_hash();
        logic [`WP_BLOCK_BITS-1:0] padded;
        // A single 0x80 byte and a zero bit length in the tail.
        padded = {8'h80, 504'h0};
        model_chain = '0;
        issue_cmd(whirlpool_ctrl_pkg::CMD_INIT, rand_block());
        check_matrix("digest after init", model_chain, digest);
        absorb_checked(padded, 0);
        check_matrix("hash of the empty string", empty_digest, digest);
    endtask

    task automatic load_then_absorb();
        model_chain = rand_block();
        issue_cmd(whirlpool_ctrl_pkg::CMD_LOAD, model_chain);
        check_matrix("digest after load", model_chain, digest);
        check_flag("done after load", 1'b0, done);
        // Each next absorb lands in the done cycle of the one before.
        repeat (4) begin
            absorb_checked(rand_block(), 0);
        end
        idle_no_done(3);
    endtask

    task automatic busy_drops_commands();
        absorb_checked(rand_block(), 6);
        idle_no_done(`WP_ROUNDS + 2);
    endtask

    task automatic init_mid_sequence();
        absorb_checked(rand_block(), 0);
        model_chain = '0;
        issue_cmd(whirlpool_ctrl_pkg::CMD_INIT, rand_block());
        check_matrix("digest after init", model_chain, digest);
        check_flag("done after init", 1'b0, done);
        idle_no_done(2);
        absorb_checked(rand_block(), 0);
    endtask

    initial begin
        seed = 32'h4025_ef1c;
        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd = whirlpool_ctrl_pkg::CMD_INIT;
        block = '0;
        model_chain = '0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        after_reset();
        empty_string_hash();
        load_then_absorb();
        busy_drops_commands();
        init_mid_sequence();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/whirlpool_ctrl_pkg.sv
common/whirlpool_data_pkg.sv
whirlpool_cipher/whirlpool_sbox.sv
whirlpool_cipher/whirlpool_round.sv
whirlpool_cipher/whirlpool_cipher.sv
src/whirlpool_chain_regs.sv
src/whirlpool_ctrl.sv
src/whirlpool_top.sv
test/whirlpool_assert.sv
test/whirlpool_tb.sv
